//--- flist.f
verilog/pe_pkg.sv
verilog/pe_requant.sv
verilog/pe_row.sv
verilog/pe_qz_pack.sv
verilog/pe_array_top.sv
test/tb_clk_gen.sv
test/pe_array_sva.sv
test/tb_pe_array.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PE array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_pe_array -o tb_pe_array
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pe_array > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- test/pe_array_sva.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array_sva (
    input logic                      clk,
    input logic                      reset,
    input logic [pe_pkg::ROWS-1:0]   q_word_valid_flat
);

    // ====================
    // packer output strobes
    // ====================
    for (genvar r = 0; r < pe_pkg::ROWS; r++) begin : g_row
        // one strobe per eight bytes and never two in a row
        a_single_cycle : assert property (@(posedge clk) disable iff (reset)
            q_word_valid_flat[r] |=> !q_word_valid_flat[r])
            else $error("row %0d word valid high in two consecutive cycles", r);
    end

    // packers come out of reset quiet
    a_quiet_after_reset : assert property (@(posedge clk)
        reset |=> (q_word_valid_flat == '0))
        else $error("word valid high in the cycle after reset");

endmodule

bind pe_array_top pe_array_sva sva_i (
    .clk               (clk),
    .reset             (reset),
    .q_word_valid_flat (q_word_valid_flat)
);

`default_nettype wire

//--- test/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    // free-running, starts low
    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- test/tb_pe_array.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pe_array;

    localparam int W = pe_pkg::WORD_W;
    localparam int R = pe_pkg::ROWS;
    localparam int IDLE = 6;
    // worst case: every group at full length plus full gap
    localparam int STIM_CYCLES = 8 + 24 * (16 + 3) + 16 * 8 + 16 * (4 + 1) + 32
                                 + 24 * (16 + 3) + 24 * (6 + 2) + 6 * IDLE + 2 * (1 + 3) + 12;

    logic clk;
    logic reset;
    logic [pe_pkg::SCALE_W-1:0] cfg_m0_scale;
    logic [pe_pkg::IDX_W-1:0]   cfg_index;
    logic [pe_pkg::ZW_W-1:0]    cfg_z_of_weight;
    logic [pe_pkg::BYTE_W-1:0]  cfg_z3;
    logic [W-1:0]               ker;
    logic signed [pe_pkg::BIAS_W-1:0] bias;
    logic [R*W-1:0]             act_flat;
    logic [R-1:0]               valid_flat;
    logic [R-1:0]               final_flat;
    logic [R*W-1:0]             q_word_flat;
    logic [R-1:0]               q_word_valid_flat;

    integer seed = 32'h24a3d4f8;
    int cyc;
    int word_errors;
    int count_errors;
    int other_errors;
    bit saw_zero;
    bit saw_max;

    // ====================
    // reference model state
    // ====================
    logic [W-1:0]                     ker_hist  [8];
    logic signed [pe_pkg::BIAS_W-1:0] bias_hist [8];
    longint acc_model [R];
    logic [W-1:0] part_word [R];
    int part_cnt [R];
    logic [W-1:0] exp_words [R][$];
    int made_words [R];
    int got_words [R];
    logic [31:0] cur_m0;
    int cur_idx;
    int cur_zw;
    int cur_z3;

    tb_clk_gen #(.PERIOD_NS(4.0)) clk_gen_i (.clk(clk));

    pe_array_top dut_i (
        .clk               (clk),
        .reset             (reset),
        .cfg_m0_scale      (cfg_m0_scale),
        .cfg_index         (cfg_index),
        .cfg_z_of_weight   (cfg_z_of_weight),
        .cfg_z3            (cfg_z3),
        .ker               (ker),
        .bias              (bias),
        .act_flat          (act_flat),
        .valid_flat        (valid_flat),
        .final_flat        (final_flat),
        .q_word_flat       (q_word_flat),
        .q_word_valid_flat (q_word_valid_flat)
    );

    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic longint dot_model(input logic [W-1:0] a, input logic [W-1:0] w,
                                         input int zw);
        longint s;
        s = 0;
        for (int k = 0; k < pe_pkg::ACT_BYTES; k++)
            s = s + longint'(a[8*k +: 8]) * (longint'(w[8*k +: 8]) - zw);
        return s;
    endfunction

    // Q31 scale, round half up at bit 30+idx, offset and clamp to a byte
    function automatic logic [7:0] requant_model(input longint total, input logic [31:0] m0,
                                                 input int idx, input int z3);
        longint scaled;
        scaled = total * longint'({32'b0, m0});
        scaled = (scaled + (longint'(1) << (30 + idx))) >>> (31 + idx);
        scaled = scaled + z3;
        if (scaled < 0)
            return 8'd0;
        else if (scaled > 255)
            return 8'd255;
        else
            return scaled[7:0];
    endfunction

    task automatic push_byte(input int r, input logic [7:0] qb);
        if (qb == 8'd0)
            saw_zero = 1'b1;
        if (qb == 8'd255)
            saw_max = 1'b1;
        part_word[r][part_cnt[r]*8 +: 8] = qb;
        part_cnt[r]++;
        if (part_cnt[r] == pe_pkg::PACK_COUNT) begin
            exp_words[r].push_back(part_word[r]);
            made_words[r]++;
            part_cnt[r] = 0;
        end
    endtask

    // new kernel and bias every cycle, kept in the history
    task automatic drive_top_words(input int bias_mode);
        ker = {$random(seed), $random(seed)};
        if (bias_mode == 1)
            bias = ($random(seed) & 1) ? 32'sd1048576 : -32'sd1048576;
        else
            bias = $random(seed) % 1048576;
        cyc++;
        ker_hist[cyc % 8]  = ker;
        bias_hist[cyc % 8] = bias;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            drive_top_words(0);
            valid_flat = '0;
            final_flat = '0;
        end
    endtask

    task automatic set_cfg();
        @(negedge clk);
        drive_top_words(0);
        valid_flat = '0;
        final_flat = '0;
        cur_m0  = $random(seed) & 32'h7fffffff;
        cur_idx = rand_range(16);
        cur_zw  = rand_range(256);
        cur_z3  = rand_range(256);
        cfg_m0_scale    = cur_m0;
        cfg_index       = 8'(cur_idx);
        cfg_z_of_weight = 16'(cur_zw);
        cfg_z3          = 8'(cur_z3);
    endtask

    // ====================
    // grouped stimulus, every row gets n_groups groups
    // ====================
    task automatic run_groups(input int n_groups, input int max_len, input int max_gap,
                              input int bias_mode);
        int groups_left [R];
        int beats_left [R];
        int gap_left [R];
        logic [W-1:0] a;
        int h;
        bit busy;
        for (int r = 0; r < R; r++) begin
            groups_left[r] = n_groups;
            beats_left[r]  = 0;
            gap_left[r]    = 0;
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            drive_top_words(bias_mode);
            busy = 1'b0;
            for (int r = 0; r < R; r++) begin
                valid_flat[r] = 1'b0;
                final_flat[r] = 1'b0;
                if (groups_left[r] > 0 && gap_left[r] > 0) begin
                    gap_left[r]--;
                end else if (groups_left[r] > 0) begin
                    if (beats_left[r] == 0)
                        beats_left[r] = 1 + rand_range(max_len);
                    a = {$random(seed), $random(seed)};
                    act_flat[r*W +: W] = a;
                    valid_flat[r] = 1'b1;
                    // row r sees the top inputs of r+1 cycles ago
                    h = (cyc - r - 1) % 8;
                    acc_model[r] += dot_model(a, ker_hist[h], cur_zw);
                    beats_left[r]--;
                    if (beats_left[r] == 0) begin
                        final_flat[r] = 1'b1;
                        push_byte(r, requant_model(acc_model[r] + bias_hist[h], cur_m0,
                                                   cur_idx, cur_z3));
                        acc_model[r] = 0;
                        groups_left[r]--;
                        gap_left[r] = rand_range(max_gap + 1);
                    end
                end
                if (groups_left[r] > 0)
                    busy = 1'b1;
            end
        end
    endtask

    task automatic check_word(input string name, input logic [W-1:0] expected,
                              input logic [W-1:0] actual);
        if (actual !== expected) begin
            word_errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            count_errors++;
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            for (int r = 0; r < R; r++) begin
                if (q_word_valid_flat[r]) begin
                    got_words[r]++;
                    if (exp_words[r].size() == 0) begin
                        other_errors++;
                        $display("row %0d produced a word when none was expected", r);
                    end else begin
                        check_word($sformatf("row%0d_word%0d", r, got_words[r] - 1),
                                   exp_words[r].pop_front(), q_word_flat[r*W +: W]);
                    end
                end
            end
        end
    end

    initial begin
        #(real'(STIM_CYCLES + 200) * 4.0);
        $display("timeout: run did not finish within %0d cycles", STIM_CYCLES + 200);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        // inputs start at the cfg reset defaults so the first runs keep them
        cur_m0 = 32'h4c138271;
        cur_idx = 7;
        cur_zw = 158;
        cur_z3 = 0;
        reset = 1'b1;
        cfg_m0_scale = cur_m0;
        cfg_index = 8'd7;
        cfg_z_of_weight = 16'd158;
        cfg_z3 = 8'd0;
        ker = '0;
        bias = '0;
        act_flat = '0;
        valid_flat = '0;
        final_flat = '0;
        cyc = 8;
        for (int i = 0; i < 8; i++) begin
            ker_hist[i]  = '0;
            bias_hist[i] = '0;
        end
        for (int r = 0; r < R; r++) begin
            acc_model[r] = 0;
            part_word[r] = '0;
            part_cnt[r] = 0;
            made_words[r] = 0;
            got_words[r] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // default cfg: random groups, long groups, clamp, single beats
        run_groups(24, 16, 3, 0);
        drive_idle(IDLE);
        run_groups(16, 8, 0, 0);
        drive_idle(IDLE);
        run_groups(16, 4, 1, 1);
        drive_idle(IDLE);
        run_groups(32, 1, 0, 0);
        drive_idle(IDLE);

        // new cfg between idle stretches
        set_cfg();
        drive_idle(3);
        run_groups(24, 16, 3, 0);
        drive_idle(IDLE);
        set_cfg();
        drive_idle(3);
        run_groups(24, 6, 2, 0);
        drive_idle(12);

        for (int r = 0; r < R; r++)
            check_count($sformatf("row%0d_word_count", r), made_words[r], got_words[r]);
        if (!saw_zero || !saw_max) begin
            other_errors++;
            $display("requant never clamped to both 0 and 255");
        end
        $display("errors: word %0d, count %0d, other %0d",
                 word_errors, count_errors, other_errors);
        if (word_errors + count_errors + other_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pe_array_top.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [pe_pkg::SCALE_W-1:0]            cfg_m0_scale,
    input  logic [pe_pkg::IDX_W-1:0]              cfg_index,
    input  logic [pe_pkg::ZW_W-1:0]               cfg_z_of_weight,
    input  logic [pe_pkg::BYTE_W-1:0]             cfg_z3,
    input  logic [pe_pkg::WORD_W-1:0]             ker,
    input  logic [pe_pkg::BIAS_W-1:0]             bias,
    input  logic [pe_pkg::ROWS*pe_pkg::WORD_W-1:0] act_flat,
    input  logic [pe_pkg::ROWS-1:0]               valid_flat,
    input  logic [pe_pkg::ROWS-1:0]               final_flat,
    output logic [pe_pkg::ROWS*pe_pkg::WORD_W-1:0] q_word_flat,
    output logic [pe_pkg::ROWS-1:0]               q_word_valid_flat
);

    logic [pe_pkg::SCALE_W-1:0] m0_scale_r;
    logic [pe_pkg::IDX_W-1:0]   index_r;
    logic [pe_pkg::ZW_W-1:0]    z_of_weight_r;
    logic [pe_pkg::BYTE_W-1:0]  z3_r;

    // entry r feeds row r, entry r+1 is what row r passes on
    logic [pe_pkg::WORD_W-1:0]        ker_chain  [0:pe_pkg::ROWS];
    logic signed [pe_pkg::BIAS_W-1:0] bias_chain [0:pe_pkg::ROWS];

    logic [pe_pkg::BYTE_W-1:0] q_byte  [0:pe_pkg::ROWS-1];
    logic                      q_valid [0:pe_pkg::ROWS-1];

    // ====================
    // configuration register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            m0_scale_r    <= pe_pkg::M0_RESET;
            index_r       <= pe_pkg::INDEX_RESET;
            z_of_weight_r <= pe_pkg::ZW_RESET;
            z3_r          <= pe_pkg::Z3_RESET;
        end else begin
            m0_scale_r    <= cfg_m0_scale;
            index_r       <= cfg_index;
            z_of_weight_r <= cfg_z_of_weight;
            z3_r          <= cfg_z3;
        end
    end

    assign ker_chain[0]  = ker;
    assign bias_chain[0] = bias;

    // ====================
    // row chain and packers
    // ====================
    for (genvar r = 0; r < pe_pkg::ROWS; r++) begin : g_row
        pe_row row_i (
            .clk             (clk),
            .reset           (reset),
            .cfg_m0_scale    (m0_scale_r),
            .cfg_index       (index_r),
            .cfg_z_of_weight (z_of_weight_r),
            .cfg_z3          (z3_r),
            .ker_in          (ker_chain[r]),
            .bias_in         (bias_chain[r]),
            .act             (act_flat[r*pe_pkg::WORD_W +: pe_pkg::WORD_W]),
            .valid           (valid_flat[r]),
            .final_beat      (final_flat[r]),
            .ker_pass        (ker_chain[r+1]),
            .bias_pass       (bias_chain[r+1]),
            .q               (q_byte[r]),
            .q_valid         (q_valid[r])
        );

        pe_qz_pack pack_i (
            .clk        (clk),
            .reset      (reset),
            .byte_in    (q_byte[r]),
            .byte_valid (q_valid[r]),
            .word       (q_word_flat[r*pe_pkg::WORD_W +: pe_pkg::WORD_W]),
            .word_valid (q_word_valid_flat[r])
        );
    end

endmodule

`default_nettype wire

//--- verilog/pe_pkg.sv
`default_nettype none

package pe_pkg;

    // ====================
    // array shape
    // ====================
    localparam int ROWS      = 4;
    localparam int BYTE_W    = 8;
    localparam int ACT_BYTES = 8;
    localparam int WORD_W    = BYTE_W * ACT_BYTES;

    // arithmetic widths
    localparam int BIAS_W  = 32;
    localparam int ACC_W   = 32;
    localparam int SCALE_W = 32;
    // shift index, only 0..15 supported
    localparam int IDX_W   = 8;
    localparam int ZW_W    = 16;

    // output packer
    localparam int PACK_COUNT = 8;
    localparam int PACK_CNT_W = $clog2(PACK_COUNT);
    localparam logic [PACK_CNT_W-1:0] PACK_LAST = PACK_CNT_W'(PACK_COUNT - 1);

    // ====================
    // configuration defaults after reset
    // ====================
    localparam logic [SCALE_W-1:0] M0_RESET    = 32'h4c138271;
    localparam logic [IDX_W-1:0]   INDEX_RESET = 8'd7;
    localparam logic [ZW_W-1:0]    ZW_RESET    = 16'd158;
    localparam logic [BYTE_W-1:0]  Z3_RESET    = 8'd0;

endpackage

`default_nettype wire

//--- verilog/pe_qz_pack.sv
`timescale 1ns/10ps
`default_nettype none

module pe_qz_pack (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [pe_pkg::BYTE_W-1:0] byte_in,
    input  logic                      byte_valid,
    output logic [pe_pkg::WORD_W-1:0] word,
    output logic                      word_valid
);

    logic [pe_pkg::PACK_CNT_W-1:0] cnt;
    logic [pe_pkg::WORD_W-1:0]     shreg;

    // ====================
    // byte counter
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt        <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= byte_valid && (cnt == pe_pkg::PACK_LAST);
            if (byte_valid)
                cnt <= cnt + 1'b1;
        end
    end

    // new byte enters at the top, so the first byte of a run ends in the low lane
    always_ff @(posedge clk) begin
        if (byte_valid)
            shreg <= {byte_in, shreg[pe_pkg::WORD_W-1:pe_pkg::BYTE_W]};
    end

    // word stays put through the valid cycle even if the next run starts
    assign word = shreg;

endmodule

`default_nettype wire

//--- verilog/pe_requant.sv
`timescale 1ns/10ps
`default_nettype none

module pe_requant (
    input  logic                             clk,
    input  logic                             reset,
    input  logic signed [pe_pkg::ACC_W-1:0]  sum,
    input  logic signed [pe_pkg::BIAS_W-1:0] bias_val,
    input  logic                             close,
    input  logic [pe_pkg::SCALE_W-1:0]       cfg_m0_scale,
    input  logic [pe_pkg::IDX_W-1:0]         cfg_index,
    input  logic [pe_pkg::BYTE_W-1:0]        cfg_z3,
    output logic [pe_pkg::BYTE_W-1:0]        q,
    output logic                             q_valid
);

    logic signed [pe_pkg::ACC_W-1:0] biased;
    logic [pe_pkg::BYTE_W-1:0]       q_next;

    // ====================
    // scale, round, offset, clamp
    // ====================
    always_comb begin : scale_calc
        logic signed [pe_pkg::ACC_W+pe_pkg::SCALE_W-1:0] sb_ext;
        logic signed [pe_pkg::ACC_W+pe_pkg::SCALE_W-1:0] m0_ext;
        logic signed [pe_pkg::ACC_W+pe_pkg::SCALE_W-1:0] rnd;
        logic signed [pe_pkg::ACC_W+pe_pkg::SCALE_W-1:0] shifted;
        logic signed [pe_pkg::ACC_W+pe_pkg::SCALE_W-1:0] z3_ext;
        biased = sum + bias_val;
        sb_ext = biased;
        // multiplier is Q31 with the top bit clear
        m0_ext = cfg_m0_scale;
        rnd    = 1;
        rnd    = rnd << (30 + cfg_index);
        // half lsb added before the arithmetic shift
        shifted = (sb_ext * m0_ext + rnd) >>> (31 + cfg_index);
        z3_ext  = cfg_z3;
        shifted = shifted + z3_ext;
        if (shifted < 0)
            q_next = '0;
        else if (shifted > 255)
            q_next = '1;
        else
            q_next = shifted[pe_pkg::BYTE_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset)
            q_valid <= 1'b0;
        else
            q_valid <= close;
    end

    always_ff @(posedge clk) begin
        if (close)
            q <= q_next;
    end

endmodule

`default_nettype wire

//--- verilog/pe_row.sv
`timescale 1ns/10ps
`default_nettype none

module pe_row (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [pe_pkg::SCALE_W-1:0]       cfg_m0_scale,
    input  logic [pe_pkg::IDX_W-1:0]         cfg_index,
    input  logic [pe_pkg::ZW_W-1:0]          cfg_z_of_weight,
    input  logic [pe_pkg::BYTE_W-1:0]        cfg_z3,
    input  logic [pe_pkg::WORD_W-1:0]        ker_in,
    input  logic signed [pe_pkg::BIAS_W-1:0] bias_in,
    input  logic [pe_pkg::WORD_W-1:0]        act,
    input  logic                             valid,
    input  logic                             final_beat,
    output logic [pe_pkg::WORD_W-1:0]        ker_pass,
    output logic signed [pe_pkg::BIAS_W-1:0] bias_pass,
    output logic [pe_pkg::BYTE_W-1:0]        q,
    output logic                             q_valid
);

    logic signed [pe_pkg::ACC_W-1:0]  dot;
    logic signed [pe_pkg::ACC_W-1:0]  acc;
    logic signed [pe_pkg::ACC_W-1:0]  sum_q;
    logic signed [pe_pkg::BIAS_W-1:0] bias_q;
    logic                             close;

    // pass registers, the local kernel and bias are one cycle behind the input
    always_ff @(posedge clk) begin
        ker_pass  <= ker_in;
        bias_pass <= bias_in;
    end

    // ====================
    // eight-byte dot product
    // ====================
    always_comb begin : dot_calc
        logic signed [pe_pkg::ACC_W-1:0] a_ext;
        logic signed [pe_pkg::ACC_W-1:0] w_ext;
        logic signed [pe_pkg::ACC_W-1:0] zw_ext;
        zw_ext = cfg_z_of_weight;
        dot    = '0;
        for (int k = 0; k < pe_pkg::ACT_BYTES; k++) begin
            a_ext = act[k*pe_pkg::BYTE_W +: pe_pkg::BYTE_W];
            w_ext = ker_pass[k*pe_pkg::BYTE_W +: pe_pkg::BYTE_W];
            // activation is unsigned, kernel is offset by its zero point
            dot   = dot + a_ext * (w_ext - zw_ext);
        end
    end

    // accumulator and close strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= '0;
            close <= 1'b0;
        end else begin
            close <= valid && final_beat;
            if (valid) begin
                // next group starts from zero
                if (final_beat)
                    acc <= '0;
                else
                    acc <= acc + dot;
            end
        end
    end

    // closed sum and its bias, held for requant
    always_ff @(posedge clk) begin
        if (valid && final_beat) begin
            sum_q  <= acc + dot;
            bias_q <= bias_pass;
        end
    end

    pe_requant requant_i (
        .clk          (clk),
        .reset        (reset),
        .sum          (sum_q),
        .bias_val     (bias_q),
        .close        (close),
        .cfg_m0_scale (cfg_m0_scale),
        .cfg_index    (cfg_index),
        .cfg_z3       (cfg_z3),
        .q            (q),
        .q_valid      (q_valid)
    );

endmodule

`default_nettype wire
